// File: design/mem_access_pkg.sv
// memory access types shared by the access controller, aligner and word bank
`default_nettype none

package mem_access_pkg;

   // access width as encoded in the low two bits of the core's ctrl field
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } access_size_e;

   // bit 2 of ctrl selects zero extension on loads
   typedef struct packed {
      logic         is_unsigned;
      access_size_e size;
   } access_ctrl_t;

   // request toward the word memory
   typedef struct packed {
      logic        rd;       // single-cycle read strobe
      logic        we;       // single-cycle write strobe
      logic        refresh;  // single-cycle refresh strobe
      logic [29:0] addr;     // word address
      logic [31:0] wdata;
      logic [3:0]  mask;     // 1 = byte gets written
   } mem_req_t;

   // response from the word memory
   typedef struct packed {
      logic        busy;
      logic [31:0] rdata;    // valid once busy drops
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: design/load_align.sv
// load aligner that shifts two read words by the byte offset and extends to the load size
`timescale 1ns/1ps
`default_nettype none

module load_align (
   input  wire [31:0]                   i_lo_word,
   input  wire [31:0]                   i_hi_word,
   input  wire [1:0]                    i_offset,
   input  mem_access_pkg::access_ctrl_t i_ctrl,
   output logic [31:0]                  o_rdata
);

   import mem_access_pkg::*;

   logic [55:0] joined;
   logic [55:0] shifted;
   logic [31:0] aligned;

   // 4 + 3 bytes cover every offset
   assign joined  = {i_hi_word[23:0], i_lo_word};
   assign shifted = joined >> {i_offset, 3'b000};
   assign aligned = shifted[31:0];

   always_comb begin
      case (i_ctrl.size)
         SZ_BYTE: begin
            if (i_ctrl.is_unsigned) o_rdata = {24'b0, aligned[7:0]};
            else                    o_rdata = {{24{aligned[7]}}, aligned[7:0]};
         end
         SZ_HALF: begin
            if (i_ctrl.is_unsigned) o_rdata = {16'b0, aligned[15:0]};
            else                    o_rdata = {{16{aligned[15]}}, aligned[15:0]};
         end
         default: o_rdata = aligned;  // full word
      endcase
   end

endmodule

`default_nettype wire

// File: design/refresh_timer.sv
// refresh timer that flags a due refresh and latches a late one
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
   parameter int REFRESH_INTERVAL = 60,
   parameter int REFRESH_LIMIT    = 90
) (
   input  wire  clk,
   input  wire  rst_x,
   input  wire  i_refresh_start,
   output logic o_refresh_due,
   output logic o_late_refresh
);

   localparam int CNT_W = $clog2(REFRESH_LIMIT + 2);

   logic [CNT_W-1:0] r_count;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_count        <= '0;
         o_late_refresh <= 1'b0;
      end else begin
         if (i_refresh_start)
            r_count <= '0;
         else if (r_count != '1)
            r_count <= r_count + 1'b1;  // saturate at all ones
         if (r_count > CNT_W'(REFRESH_LIMIT))
            o_late_refresh <= 1'b1;     // sticky until reset
      end
   end

   assign o_refresh_due = r_count > CNT_W'(REFRESH_INTERVAL);

endmodule

`default_nettype wire

// File: design/word_mem_bank.sv
// word-wide memory bank with byte mask writes and a fixed busy time per access
`timescale 1ns/1ps
`default_nettype none

module word_mem_bank #(
   parameter int ADDR_W         = 10,
   parameter int MEM_LATENCY    = 3,
   parameter int REFRESH_CYCLES = 4
) (
   input  wire                      clk,
   input  wire                      rst_x,
   input  mem_access_pkg::mem_req_t i_req,
   output mem_access_pkg::mem_rsp_t o_rsp
);

   localparam int CNT_MAX = (MEM_LATENCY > REFRESH_CYCLES) ? MEM_LATENCY : REFRESH_CYCLES;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   logic [31:0]      mem [2**ADDR_W];
   logic [ADDR_W-1:0] idx;

   logic [CNT_W-1:0] r_cnt;      // remaining busy cycles
   logic             r_rd_pend;  // read result waiting for end of busy
   logic [31:0]      r_hold;
   logic [31:0]      r_rdata;

   assign idx = i_req.addr[ADDR_W-1:0];

   // array access happens in the request cycle
   always_ff @(posedge clk) begin
      if (i_req.we) begin
         for (int b = 0; b < 4; b++) begin
            if (i_req.mask[b]) mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
         end
      end
      if (i_req.rd) r_hold <= mem[idx];
      if (r_rd_pend && (r_cnt == CNT_W'(1)))
         r_rdata <= r_hold;  // shows up as busy drops
   end

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_cnt     <= '0;
         r_rd_pend <= 1'b0;
      end else begin
         if (i_req.rd || i_req.we)
            r_cnt <= CNT_W'(MEM_LATENCY);
         else if (i_req.refresh)
            r_cnt <= CNT_W'(REFRESH_CYCLES);
         else if (r_cnt != '0)
            r_cnt <= r_cnt - 1'b1;

         if (i_req.rd)
            r_rd_pend <= 1'b1;
         else if (r_cnt == CNT_W'(1))
            r_rd_pend <= 1'b0;
      end
   end

   assign o_rsp = '{busy: (r_cnt != '0), rdata: r_rdata};

endmodule

`default_nettype wire

// File: design/unaligned_access_ctrl.sv
// access controller that splits unaligned loads and stores into word accesses and runs refresh
`timescale 1ns/1ps
`default_nettype none

module unaligned_access_ctrl (
   input  wire                          clk,
   input  wire                          rst_x,
   input  wire                          i_rd_en,
   input  wire                          i_wr_en,
   input  wire [31:0]                   i_addr,
   input  wire [31:0]                   i_wdata,
   input  mem_access_pkg::access_ctrl_t i_ctrl,
   input  mem_access_pkg::mem_rsp_t     i_mem_rsp,
   input  wire                          i_refresh_due,
   output mem_access_pkg::mem_req_t     o_mem_req,
   output logic                         o_busy,
   output logic                         o_refresh_start,
   output logic [31:0]                  o_lo_word,
   output logic [31:0]                  o_hi_word,
   output logic [1:0]                   o_offset,
   output mem_access_pkg::access_ctrl_t o_ctrl
);

   import mem_access_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT_HI,   // strobe sent, waiting for the bank to go busy
      S_WAIT_LO,   // bank busy, waiting for it to finish
      S_DONE
   } state_e;

   typedef enum logic [1:0] {
      OP_LOAD,
      OP_STORE,
      OP_REFRESH
   } op_e;

   state_e      r_state;
   op_e         r_op;
   logic        r_phase;     // 0 on the first word, 1 on the carried word
   logic        r_busy;
   logic        r_rd;
   logic        r_we;
   logic        r_refresh;

   logic        r_split;
   logic [29:0] r_maddr;
   logic [31:0] r_mwdata;
   logic [3:0]  r_mmask;
   logic [31:0] r_hi_wdata;
   logic [3:0]  r_hi_mask;

   logic [31:0] size_data;
   logic [3:0]  size_mask;
   logic [2:0]  size_bytes;
   logic [63:0] st_shift;
   logic [7:0]  st_mask;
   logic        split;

   logic        accept_rd;
   logic        accept_wr;
   logic        start_ref;
   logic        mem_done;
   logic        go_second;

   // store data and mask placed across two adjacent words
   always_comb begin
      case (i_ctrl.size)
         SZ_BYTE: begin
            size_data  = {24'b0, i_wdata[7:0]};
            size_mask  = 4'b0001;
            size_bytes = 3'd1;
         end
         SZ_HALF: begin
            size_data  = {16'b0, i_wdata[15:0]};
            size_mask  = 4'b0011;
            size_bytes = 3'd2;
         end
         default: begin
            size_data  = i_wdata;
            size_mask  = 4'b1111;
            size_bytes = 3'd4;
         end
      endcase
   end

   assign st_shift = {32'b0, size_data} << {i_addr[1:0], 3'b000};
   assign st_mask  = {4'b0, size_mask} << i_addr[1:0];
   assign split    = ({1'b0, i_addr[1:0]} + size_bytes) > 3'd4;  // spills into next word

   // read wins over write, any request wins over refresh
   assign accept_rd = (r_state == S_IDLE) && !r_busy && i_rd_en;
   assign accept_wr = (r_state == S_IDLE) && !r_busy && !i_rd_en && i_wr_en;
   assign start_ref = (r_state == S_IDLE) && !r_busy && !i_rd_en && !i_wr_en && i_refresh_due;

   assign mem_done  = (r_state == S_WAIT_LO) && !i_mem_rsp.busy;
   assign go_second = mem_done && (r_op != OP_REFRESH) && !r_phase && r_split;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_state   <= S_IDLE;
         r_op      <= OP_LOAD;
         r_phase   <= 1'b0;
         r_busy    <= 1'b0;
         r_rd      <= 1'b0;
         r_we      <= 1'b0;
         r_refresh <= 1'b0;
      end else begin
         r_rd      <= 1'b0;  // strobes last one cycle
         r_we      <= 1'b0;
         r_refresh <= 1'b0;
         case (r_state)
            S_IDLE: begin
               r_phase <= 1'b0;
               if (accept_rd) begin
                  r_rd    <= 1'b1;
                  r_busy  <= 1'b1;
                  r_op    <= OP_LOAD;
                  r_state <= S_WAIT_HI;
               end else if (accept_wr) begin
                  r_we    <= 1'b1;
                  r_busy  <= 1'b1;
                  r_op    <= OP_STORE;
                  r_state <= S_WAIT_HI;
               end else if (start_ref) begin
                  r_refresh <= 1'b1;
                  r_busy    <= 1'b1;
                  r_op      <= OP_REFRESH;
                  r_state   <= S_WAIT_HI;
               end
            end
            S_WAIT_HI: begin
               if (i_mem_rsp.busy) r_state <= S_WAIT_LO;
            end
            S_WAIT_LO: begin
               if (go_second) begin
                  r_phase <= 1'b1;
                  if (r_op == OP_LOAD) r_rd <= 1'b1;
                  else                 r_we <= 1'b1;
                  r_state <= S_WAIT_HI;
               end else if (mem_done) begin
                  r_state <= S_DONE;
               end
            end
            S_DONE: begin
               r_busy  <= 1'b0;
               r_state <= S_IDLE;
            end
            default: r_state <= S_IDLE;
         endcase
      end
   end

   // address, data and captured read words
   always_ff @(posedge clk) begin
      if (accept_rd || accept_wr) begin
         r_maddr    <= i_addr[31:2];
         r_mwdata   <= st_shift[31:0];
         r_mmask    <= accept_wr ? st_mask[3:0] : 4'b0000;
         r_hi_wdata <= st_shift[63:32];
         r_hi_mask  <= st_mask[7:4];
         r_split    <= split;
      end
      if (accept_rd) begin
         o_offset <= i_addr[1:0];  // held for the aligner until the next load
         o_ctrl   <= i_ctrl;
      end
      if (go_second) begin
         r_maddr  <= r_maddr + 30'd1;
         r_mwdata <= r_hi_wdata;
         r_mmask  <= (r_op == OP_STORE) ? r_hi_mask : 4'b0000;
      end
      if (mem_done && (r_op == OP_LOAD)) begin
         if (r_phase) o_hi_word <= i_mem_rsp.rdata;
         else         o_lo_word <= i_mem_rsp.rdata;
      end
   end

   assign o_mem_req = '{rd:      r_rd,
                        we:      r_we,
                        refresh: r_refresh,
                        addr:    r_maddr,
                        wdata:   r_mwdata,
                        mask:    r_mmask};

   assign o_busy          = r_busy;
   assign o_refresh_start = r_refresh;  // timer restarts its count

endmodule

`default_nettype wire

// File: design/dram_subsys.sv
// data memory subsystem joining the access controller, load aligner, refresh timer and bank
`timescale 1ns/1ps
`default_nettype none

module dram_subsys #(
   parameter int ADDR_W           = 10,
   parameter int MEM_LATENCY      = 3,
   parameter int REFRESH_CYCLES   = 4,
   parameter int REFRESH_INTERVAL = 60,
   parameter int REFRESH_LIMIT    = 90
) (
   input  wire                          clk,
   input  wire                          rst_x,
   input  wire                          i_rd_en,
   input  wire                          i_wr_en,
   input  wire [31:0]                   i_addr,
   input  wire [31:0]                   i_wdata,
   input  mem_access_pkg::access_ctrl_t i_ctrl,
   output logic [31:0]                  o_rdata,
   output logic                         o_busy,
   output logic                         o_late_refresh
);

   import mem_access_pkg::*;

   mem_req_t     mem_req;
   mem_rsp_t     mem_rsp;
   logic [31:0]  lo_word;
   logic [31:0]  hi_word;
   logic [1:0]   ld_offset;
   access_ctrl_t ld_ctrl;
   logic         refresh_due;
   logic         refresh_start;

   unaligned_access_ctrl i_ctrl_fsm (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_rd_en         (i_rd_en),
      .i_wr_en         (i_wr_en),
      .i_addr          (i_addr),
      .i_wdata         (i_wdata),
      .i_ctrl          (i_ctrl),
      .i_mem_rsp       (mem_rsp),
      .i_refresh_due   (refresh_due),
      .o_mem_req       (mem_req),
      .o_busy          (o_busy),
      .o_refresh_start (refresh_start),
      .o_lo_word       (lo_word),
      .o_hi_word       (hi_word),
      .o_offset        (ld_offset),
      .o_ctrl          (ld_ctrl)
   );

   load_align i_load_align (
      .i_lo_word (lo_word),
      .i_hi_word (hi_word),
      .i_offset  (ld_offset),
      .i_ctrl    (ld_ctrl),
      .o_rdata   (o_rdata)
   );

   refresh_timer #(
      .REFRESH_INTERVAL (REFRESH_INTERVAL),
      .REFRESH_LIMIT    (REFRESH_LIMIT)
   ) i_refresh_timer (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_refresh_start (refresh_start),
      .o_refresh_due   (refresh_due),
      .o_late_refresh  (o_late_refresh)
   );

   word_mem_bank #(
      .ADDR_W         (ADDR_W),
      .MEM_LATENCY    (MEM_LATENCY),
      .REFRESH_CYCLES (REFRESH_CYCLES)
   ) i_word_mem_bank (
      .clk   (clk),
      .rst_x (rst_x),
      .i_req (mem_req),
      .o_rsp (mem_rsp)
   );

endmodule

`default_nettype wire

// File: verification/dram_subsys_checker.sv
// assertion checker for the caller handshake and the word memory strobes
`timescale 1ns/1ps
`default_nettype none

module dram_subsys_checker (
   input wire                      clk,
   input wire                      rst_x,
   input wire                      i_rd_en,
   input wire                      i_wr_en,
   input wire                      i_busy,
   input mem_access_pkg::mem_req_t i_mem_req
);

   // busy low means the controller sits in idle
   busy_after_accept: assert property (
      @(posedge clk) disable iff (!rst_x)
      (!i_busy && (i_rd_en || i_wr_en)) |=> i_busy
   ) else $error("o_busy stayed low after an accepted request");

   strobes_exclusive: assert property (
      @(posedge clk) disable iff (!rst_x)
      $onehot0({i_mem_req.rd, i_mem_req.we, i_mem_req.refresh})
   ) else $error("more than one memory strobe active");

   write_has_mask: assert property (
      @(posedge clk) disable iff (!rst_x)
      i_mem_req.we |-> (i_mem_req.mask != 4'b0000)
   ) else $error("memory write with an empty byte mask");

   idle_after_reset: assert property (
      @(posedge clk) !rst_x |=> !i_busy
   ) else $error("o_busy high after reset");

endmodule

bind dram_subsys dram_subsys_checker i_dram_subsys_checker (
   .clk       (clk),
   .rst_x     (rst_x),
   .i_rd_en   (i_rd_en),
   .i_wr_en   (i_wr_en),
   .i_busy    (o_busy),
   .i_mem_req (mem_req)
);

`default_nettype wire

// File: verification/tb_dram_subsys.sv
// testbench for the data memory subsystem, table driven against a byte-array model
`timescale 1ns/1ps
`default_nettype none

module tb_dram_subsys;

   import mem_access_pkg::*;

   localparam int          REFRESH_INTERVAL = 60;
   localparam int          REFRESH_LIMIT    = 90;
   localparam int          IDLE_CYCLES      = REFRESH_INTERVAL + 20;
   localparam int          HOLD_CYCLES      = REFRESH_LIMIT + 40;
   localparam logic [31:0] BASE             = 32'h0000_0200;
   localparam logic [31:0] RAND_SEED        = 32'h43a7_38e2;

   typedef enum logic [1:0] {T_STORE, T_LOAD, T_IDLE, T_HOLD} test_op_e;

   typedef struct packed {
      test_op_e     op;
      logic [31:0]  addr;
      access_ctrl_t ctrl;
      logic [31:0]  wdata;
      logic [31:0]  exp;    // expected o_rdata for loads
   } entry_t;

   logic         clk;
   logic         rst_x;
   logic         rd_en;
   logic         wr_en;
   logic [31:0]  addr;
   logic [31:0]  wdata;
   access_ctrl_t ctrl;
   logic [31:0]  rdata;
   logic         busy;
   logic         late;

   entry_t       tests[$];
   logic [7:0]   model [4096];  // byte image of the bank
   int           errors;
   int           cycles;
   int           cycle_limit;
   logic [31:0]  seed_sink;

   dram_subsys #(
      .REFRESH_INTERVAL (REFRESH_INTERVAL),
      .REFRESH_LIMIT    (REFRESH_LIMIT)
   ) i_dram_subsys (
      .clk            (clk),
      .rst_x          (rst_x),
      .i_rd_en        (rd_en),
      .i_wr_en        (wr_en),
      .i_addr         (addr),
      .i_wdata        (wdata),
      .i_ctrl         (ctrl),
      .o_rdata        (rdata),
      .o_busy         (busy),
      .o_late_refresh (late)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // little endian gather, then extend as the load size says
   function automatic logic [31:0] expected_load(logic [31:0] a, access_ctrl_t c);
      logic [31:0] v;
      for (int i = 0; i < 4; i++) v[8*i +: 8] = model[12'(a + i)];
      case (c.size)
         SZ_BYTE: v = c.is_unsigned ? {24'b0, v[7:0]} : {{24{v[7]}}, v[7:0]};
         SZ_HALF: v = c.is_unsigned ? {16'b0, v[15:0]} : {{16{v[15]}}, v[15:0]};
         default: ;
      endcase
      return v;
   endfunction

   function automatic void store_bytes(logic [31:0] a, access_ctrl_t c, logic [31:0] d);
      int n;
      n = (c.size == SZ_BYTE) ? 1 : (c.size == SZ_HALF) ? 2 : 4;
      for (int i = 0; i < n; i++) model[12'(a + i)] = d[8*i +: 8];
   endfunction

   function automatic void push_test(test_op_e op, logic [31:0] a, access_size_e sz,
                                     logic uns, logic [31:0] d);
      entry_t e;
      e.op    = op;
      e.addr  = a;
      e.ctrl  = '{is_unsigned: uns, size: sz};
      e.wdata = d;
      e.exp   = 32'h0;
      if (op == T_STORE) store_bytes(a, e.ctrl, d);
      else               e.exp = expected_load(a, e.ctrl);
      tests.push_back(e);
   endfunction

   // spilled store, read back, then both words around it
   function automatic void spill_store(logic [31:0] a, access_size_e sz);
      push_test(T_STORE, a, sz, 1'b0, $urandom);
      push_test(T_LOAD, a, sz, 1'b1, 32'h0);
      push_test(T_LOAD, {a[31:2], 2'b00}, SZ_WORD, 1'b0, 32'h0);
      push_test(T_LOAD, {a[31:2], 2'b00} + 32'd4, SZ_WORD, 1'b0, 32'h0);
   endfunction

   function automatic void build_tests();
      logic [31:0] a;
      // words 1 and 2 fixed so both sign cases show up
      for (int w = 0; w < 16; w++)
         push_test(T_STORE, BASE + 4*w, SZ_WORD, 1'b0,
                   (w == 1) ? 32'h8a7f_f501 : (w == 2) ? 32'h00c3_9e66 : $urandom);
      for (int w = 0; w < 16; w++)
         push_test(T_LOAD, BASE + 4*w, SZ_WORD, 1'b0, 32'h0);
      for (int off = 0; off < 4; off++) begin
         for (int u = 0; u < 2; u++) begin
            push_test(T_LOAD, BASE + 4 + off, SZ_BYTE, u[0], 32'h0);
            push_test(T_LOAD, BASE + 4 + off, SZ_HALF, u[0], 32'h0);
         end
      end
      spill_store(BASE + 32'h13, SZ_HALF);
      spill_store(BASE + 32'h19, SZ_WORD);
      spill_store(BASE + 32'h1e, SZ_WORD);
      spill_store(BASE + 32'h27, SZ_WORD);
      for (int i = 0; i < 4; i++) begin
         a = BASE + 32'h30 + 4*i + ((i + 1) % 4);  // offsets 1, 2, 3, 0
         push_test(T_STORE, a, a[0] ? SZ_BYTE : SZ_HALF, 1'b0, $urandom);
         push_test(T_LOAD, {a[31:2], 2'b00}, SZ_WORD, 1'b0, 32'h0);
      end
      push_test(T_IDLE, BASE, SZ_WORD, 1'b0, 32'h0);
      push_test(T_LOAD, BASE + 32'h19, SZ_WORD, 1'b0, 32'h0);
      push_test(T_LOAD, BASE + 32'h6, SZ_HALF, 1'b1, 32'h0);
      push_test(T_HOLD, BASE + 32'h13, SZ_HALF, 1'b0, 32'h0);
   endfunction

   task automatic run_access(entry_t e, int hold);
      @(negedge clk);                // one free edge so a due refresh can go
      while (busy) @(negedge clk);
      rd_en = (e.op != T_STORE);
      wr_en = (e.op == T_STORE);
      addr  = e.addr;
      wdata = e.wdata;
      ctrl  = e.ctrl;
      repeat (hold) @(negedge clk);
      rd_en = 1'b0;
      wr_en = 1'b0;
      while (busy) @(negedge clk);
   endtask

   task automatic idle_for_refresh(output logic seen);
      seen = 1'b0;
      repeat (IDLE_CYCLES) begin
         @(negedge clk);
         if (busy) seen = 1'b1;    // only refresh can raise busy here
      end
      while (busy) @(negedge clk);
   endtask

   task automatic compare_word(logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: o_rdata = %h, expected %h", got, exp);
         errors++;
      end
   endtask

   task automatic verify_flag(logic got, logic exp);
      if (got !== exp) begin
         $display("Error: o_late_refresh = %h, expected %h", got, exp);
         errors++;
      end
   endtask

   initial begin
      entry_t   e;
      test_op_e op;
      logic     seen;
      int       err_before;
      seed_sink   = $urandom(RAND_SEED);
      rst_x       = 1'b0;
      rd_en       = 1'b0;
      wr_en       = 1'b0;
      addr        = 32'h0;
      wdata       = 32'h0;
      ctrl        = '0;
      errors      = 0;
      cycles      = 0;
      build_tests();
      cycle_limit = tests.size() * 40 + 2000;
      repeat (4) @(negedge clk);
      rst_x = 1'b1;
      foreach (tests[i]) begin
         e          = tests[i];
         op         = e.op;
         err_before = errors;
         case (op)
            T_IDLE:  idle_for_refresh(seen);
            T_HOLD:  run_access(e, HOLD_CYCLES);
            default: run_access(e, 1);
         endcase
         if (op == T_LOAD || op == T_HOLD) compare_word(rdata, e.exp);
         if (op == T_IDLE) begin
            if (!seen) begin
               $display("no refresh cycle was seen during the idle period");
               errors++;
            end
            verify_flag(late, 1'b0);
         end
         if (op == T_HOLD) verify_flag(late, 1'b1);
         $display("test %0d %s addr %h size %0d: %s", i, op.name(), e.addr, e.ctrl.size,
                  (errors == err_before) ? "ok" : "failed");
      end
      $display("%0d tests run, %0d errors", tests.size(), errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
design/mem_access_pkg.sv
design/load_align.sv
design/refresh_timer.sv
design/word_mem_bank.sv
design/unaligned_access_ctrl.sv
design/dram_subsys.sv
verification/dram_subsys_checker.sv
verification/tb_dram_subsys.sv

// File: Bender.yml
package:
  name: dram_subsys

sources:
  - files:
      - design/mem_access_pkg.sv
      - design/load_align.sv
      - design/refresh_timer.sv
      - design/word_mem_bank.sv
      - design/unaligned_access_ctrl.sv
      - design/dram_subsys.sv
  - target: test
    files:
      - verification/dram_subsys_checker.sv
      - verification/tb_dram_subsys.sv
